//--- flashram_pkg.sv
package flashram_pkg;

    // Array geometry, a page is also the erase sector
    localparam int PAGE_COUNT = 8;
    localparam int PAGE_WORDS = 32;
    localparam int PAGE_BITS  = 3;
    localparam int ARRAY_BITS = 8;

    localparam int ADDR_BITS = 17;

    localparam logic [31:0] FLASH_TYPE_ID  = 32'h1111_8001;
    localparam logic [31:0] FLASH_MODEL_ID = 32'h00C2_001D;

    localparam logic [31:0] ERASED_WORD = 32'hFFFF_FFFF;

    typedef enum logic [7:0] {
        CMD_STATUS_MODE  = 8'hD2,
        CMD_READID_MODE  = 8'hE1,
        CMD_READ_MODE    = 8'hF0,
        CMD_ERASE_SECTOR = 8'h4B,
        CMD_ERASE_CHIP   = 8'h3C,
        CMD_BUFFER_MODE  = 8'hB4,
        CMD_ERASE_START  = 8'h78,
        CMD_WRITE_START  = 8'hA5
    } cmd_e;

    typedef enum logic [1:0] {
        MODE_STATUS,
        MODE_ID,
        MODE_READ,
        MODE_BUFFER
    } mode_e;

    // Bit positions in the 4-bit status register
    localparam int STAT_WRITE_BUSY = 0;
    localparam int STAT_ERASE_BUSY = 1;
    localparam int STAT_WRITE_DONE = 2;
    localparam int STAT_ERASE_DONE = 3;

endpackage

//--- flashram_page_buffer.sv
module flashram_page_buffer (
    input  logic        sys,
    input  logic        buf_wr_low,
    input  logic        buf_wr_high,
    input  logic [4:0]  buf_word,
    input  logic [15:0] wdata,
    input  logic [4:0]  buf_raddr,
    output logic [31:0] buf_rdata
);

    logic [15:0] upper_half;
    logic [31:0] words [0:31];

    // The bus sends the upper halfword first and the lower one completes the word
    always_ff @(posedge sys) begin
        if (buf_wr_low) begin
            upper_half <= wdata;
        end
    end

    always_ff @(posedge sys) begin
        buf_rdata <= words[buf_raddr];
        if (buf_wr_high) begin
            words[buf_word] <= {upper_half, wdata};
        end
    end

endmodule

//--- flashram_ctrl.sv
module flashram_ctrl (
    input  logic                                  sys,
    input  logic                                  rst,
    input  logic                                  request,
    input  logic                                  write,
    input  logic [flashram_pkg::ADDR_BITS-1:0]    address,
    input  logic [15:0]                           wdata,
    output logic                                  ack,
    output logic [15:0]                           rdata,
    output logic                                  read_mode,
    output logic                                  buf_wr_low,
    output logic                                  buf_wr_high,
    output logic [4:0]                            buf_word,
    output logic                                  op_pending,
    output logic                                  op_erase,
    output logic                                  op_all,
    output logic [flashram_pkg::PAGE_BITS-1:0]    op_page,
    input  logic                                  op_done,
    output logic [flashram_pkg::ARRAY_BITS-1:0]   array_addr,
    input  logic [31:0]                           array_rdata
);
    import flashram_pkg::*;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_e;

    bus_state_e bus_state;
    mode_e      mode;
    cmd_e       command;
    logic       erase_armed;
    logic [3:0] status;

    logic accept;
    logic buf_write;
    logic cmd_write;

    // A request landing in the wait state after an ack is dropped
    assign accept    = request && bus_state == BUS_IDLE;
    assign buf_write = accept && write && !address[16] && mode == MODE_BUFFER;
    assign cmd_write = accept && write && address[16] && !op_pending;

    assign buf_wr_low  = buf_write && !address[1];
    assign buf_wr_high = buf_write && address[1];
    assign buf_word    = address[6:2];

    assign array_addr = address[ARRAY_BITS+1:2];
    assign read_mode  = mode == MODE_READ;

    always_comb begin
        rdata = 16'h0000;
        if (ack) begin
            case (mode)
                MODE_ID: begin
                    case (address[2:1])
                        2'd0: rdata = FLASH_TYPE_ID[31:16];
                        2'd1: rdata = FLASH_TYPE_ID[15:0];
                        2'd2: rdata = FLASH_MODEL_ID[31:16];
                        2'd3: rdata = FLASH_MODEL_ID[15:0];
                    endcase
                end
                MODE_READ: begin
                    // Halfword 0 is the upper half of the word
                    rdata = address[1] ? array_rdata[15:0] : array_rdata[31:16];
                end
                default: begin
                    if (address[1]) begin
                        rdata = {12'h000, status};
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys) begin
        if (rst) begin
            ack         <= 1'b0;
            bus_state   <= BUS_IDLE;
            mode        <= MODE_STATUS;
            status      <= 4'h0;
            erase_armed <= 1'b0;
            op_pending  <= 1'b0;
        end else begin
            ack       <= accept;
            bus_state <= accept ? BUS_WAIT : BUS_IDLE;

            if (op_done) begin
                op_pending <= 1'b0;
                if (op_erase) begin
                    status[STAT_ERASE_BUSY] <= 1'b0;
                    status[STAT_ERASE_DONE] <= 1'b1;
                end else begin
                    status[STAT_WRITE_BUSY] <= 1'b0;
                    status[STAT_WRITE_DONE] <= 1'b1;
                end
            end

            // Low halfword latches the command byte, high halfword runs it
            if (cmd_write && !address[1]) begin
                command <= cmd_e'(wdata[15:8]);
            end

            if (cmd_write && address[1]) begin
                erase_armed <= 1'b0;
                case (command)
                    CMD_STATUS_MODE: mode <= MODE_STATUS;
                    CMD_READID_MODE: mode <= MODE_ID;
                    CMD_READ_MODE:   mode <= MODE_READ;
                    CMD_BUFFER_MODE: mode <= MODE_BUFFER;
                    CMD_ERASE_SECTOR: begin
                        mode        <= MODE_STATUS;
                        erase_armed <= 1'b1;
                        op_all      <= 1'b0;
                        op_page     <= wdata[PAGE_BITS-1:0];
                    end
                    CMD_ERASE_CHIP: begin
                        mode        <= MODE_STATUS;
                        erase_armed <= 1'b1;
                        op_all      <= 1'b1;
                        op_page     <= '0;
                    end
                    CMD_ERASE_START: begin
                        mode <= MODE_STATUS;
                        if (erase_armed) begin
                            op_pending              <= 1'b1;
                            op_erase                <= 1'b1;
                            status[STAT_ERASE_BUSY] <= 1'b1;
                            status[STAT_ERASE_DONE] <= 1'b0;
                        end
                    end
                    CMD_WRITE_START: begin
                        mode                    <= MODE_STATUS;
                        op_pending              <= 1'b1;
                        op_erase                <= 1'b0;
                        op_all                  <= 1'b0;
                        op_page                 <= wdata[PAGE_BITS-1:0];
                        status[STAT_WRITE_BUSY] <= 1'b1;
                        status[STAT_WRITE_DONE] <= 1'b0;
                    end
                    default: begin
                        // Unknown codes only disarm erase
                    end
                endcase
            end
        end
    end

    // The wait state keeps acks apart so requests cannot come back to back
    assert property (@(posedge sys) disable iff (rst) ack |=> !ack);

    // The engine only finishes work it was handed
    assert property (@(posedge sys) disable iff (rst) op_done |-> op_pending);

endmodule

//--- flashram_engine.sv
module flashram_engine (
    input  logic                                  sys,
    input  logic                                  rst,
    input  logic                                  op_pending,
    input  logic                                  op_erase,
    input  logic                                  op_all,
    input  logic [flashram_pkg::PAGE_BITS-1:0]    op_page,
    output logic                                  op_done,
    output logic [4:0]                            buf_raddr,
    input  logic [31:0]                           buf_rdata,
    input  logic [flashram_pkg::ARRAY_BITS-1:0]   array_addr,
    output logic [31:0]                           array_rdata
);
    import flashram_pkg::*;

    logic [31:0] flash_mem [0:PAGE_COUNT*PAGE_WORDS-1];

    logic                  busy;
    logic                  primed;
    logic [ARRAY_BITS-1:0] word_cnt;
    logic                  last_word;

    logic                  mem_we;
    logic [ARRAY_BITS-1:0] mem_waddr;
    logic [31:0]           mem_wdata;

    // Once primed, the buffer read runs one word ahead of the array write
    assign buf_raddr = primed ? word_cnt[4:0] + 5'd1 : word_cnt[4:0];

    assign mem_we    = busy && primed;
    assign mem_waddr = op_all ? word_cnt : {op_page, word_cnt[4:0]};
    assign mem_wdata = op_erase ? ERASED_WORD : buf_rdata;

    assign last_word = op_all ? word_cnt == ARRAY_BITS'(PAGE_COUNT * PAGE_WORDS - 1)
                              : word_cnt[4:0] == 5'(PAGE_WORDS - 1);

    always_ff @(posedge sys) begin
        array_rdata <= flash_mem[array_addr];
        if (mem_we) begin
            flash_mem[mem_waddr] <= mem_wdata;
        end
    end

    always_ff @(posedge sys) begin
        if (rst) begin
            busy     <= 1'b0;
            primed   <= 1'b0;
            word_cnt <= '0;
            op_done  <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (!busy) begin
                // op_pending is still high during the done cycle
                if (op_pending && !op_done) begin
                    busy     <= 1'b1;
                    primed   <= op_erase;
                    word_cnt <= '0;
                end
            end else if (!primed) begin
                primed <= 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
                if (last_word) begin
                    busy    <= 1'b0;
                    primed  <= 1'b0;
                    op_done <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge sys) disable iff (rst) op_done |=> !op_done);

endmodule

//--- flashram_top.sv
module flashram_top (
    input  logic                               sys,
    input  logic                               rst,
    input  logic                               request,
    input  logic                               write,
    input  logic [flashram_pkg::ADDR_BITS-1:0] address,
    input  logic [15:0]                        wdata,
    output logic                               ack,
    output logic [15:0]                        rdata,
    output logic                               read_mode
);
    import flashram_pkg::*;

    logic                  buf_wr_low;
    logic                  buf_wr_high;
    logic [4:0]            buf_word;
    logic [4:0]            buf_raddr;
    logic [31:0]           buf_rdata;
    logic                  op_pending;
    logic                  op_erase;
    logic                  op_all;
    logic [PAGE_BITS-1:0]  op_page;
    logic                  op_done;
    logic [ARRAY_BITS-1:0] array_addr;
    logic [31:0]           array_rdata;

    flashram_ctrl flashram_ctrl_inst (
        .sys         (sys),
        .rst         (rst),
        .request     (request),
        .write       (write),
        .address     (address),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .read_mode   (read_mode),
        .buf_wr_low  (buf_wr_low),
        .buf_wr_high (buf_wr_high),
        .buf_word    (buf_word),
        .op_pending  (op_pending),
        .op_erase    (op_erase),
        .op_all      (op_all),
        .op_page     (op_page),
        .op_done     (op_done),
        .array_addr  (array_addr),
        .array_rdata (array_rdata)
    );

    flashram_page_buffer flashram_page_buffer_inst (
        .sys         (sys),
        .buf_wr_low  (buf_wr_low),
        .buf_wr_high (buf_wr_high),
        .buf_word    (buf_word),
        .wdata       (wdata),
        .buf_raddr   (buf_raddr),
        .buf_rdata   (buf_rdata)
    );

    flashram_engine flashram_engine_inst (
        .sys         (sys),
        .rst         (rst),
        .op_pending  (op_pending),
        .op_erase    (op_erase),
        .op_all      (op_all),
        .op_page     (op_page),
        .op_done     (op_done),
        .buf_raddr   (buf_raddr),
        .buf_rdata   (buf_rdata),
        .array_addr  (array_addr),
        .array_rdata (array_rdata)
    );

endmodule

//--- tb_flashram.sv
module tb_flashram;
    timeunit 1ns;
    timeprecision 1ps;

    import flashram_pkg::*;

    localparam logic [ADDR_BITS-1:0] STATUS_ADDR = 17'h00002;

    logic                 sys;
    logic                 rst;
    logic                 request;
    logic                 write;
    logic [ADDR_BITS-1:0] address;
    logic [15:0]          wdata;
    logic                 ack;
    logic [15:0]          rdata;
    logic                 read_mode;

    int              error_count;
    int              pass_count;
    int              fail_count;
    logic            test_open;
    logic            aborted;
    string           test_name;

    // Command register rules applied to the writes issued so far
    logic            expect_read;
    logic            expect_busy;
    logic            expect_armed;
    logic [7:0]      latched_cmd;

    flashram_top flashram_top_inst (
        .sys       (sys),
        .rst       (rst),
        .request   (request),
        .write     (write),
        .address   (address),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .read_mode (read_mode)
    );

    always #5 sys = ~sys;

    function automatic string to_text(input logic [8*40-1:0] raw);
        string s;
        s = "";
        for (int i = 39; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", raw[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    // Called on a falling edge, returns on the falling edge where the next request may start
    task automatic bus_access(input logic is_write, input logic [ADDR_BITS-1:0] addr,
                              input logic [15:0] data, output logic [15:0] captured);
        int waited;
        waited = 0;
        captured = 16'h0000;
        if (!aborted) begin
            request = 1'b1;
            write   = is_write;
            address = addr;
            wdata   = data;
            @(negedge sys);
            request = 1'b0;
            while (!ack && waited < 10) begin
                @(negedge sys);
                waited++;
            end
            if (!ack) begin
                $display("No ack arrived within 10 cycles for the request to address %h", addr);
                error_count++;
                aborted = 1'b1;
            end else begin
                captured = rdata;
                write    = 1'b0;
                // The controller drops a request in the cycle after its ack
                @(negedge sys);
            end
        end
    endtask

    task automatic poll_status(input int bit_idx, input logic expected);
        logic [15:0] got;
        int          polls;
        logic        matched;
        polls = 0;
        matched = 1'b0;
        while (!matched && !aborted && polls < 1000) begin
            bus_access(1'b0, STATUS_ADDR, 16'h0000, got);
            matched = got[bit_idx] == expected;
            polls++;
        end
        if (!matched && !aborted) begin
            $display("Status bit %0d did not reach %0d within 1000 polls", bit_idx, expected);
            error_count++;
        end
        // A done bit that came up ends the pending operation
        if (matched && expected &&
            (bit_idx == STAT_WRITE_DONE || bit_idx == STAT_ERASE_DONE)) begin
            expect_busy = 1'b0;
        end
    endtask

    // Writes while an operation is pending change nothing
    task automatic track_command(input logic [ADDR_BITS-1:0] addr, input logic [15:0] data);
        if (addr[16] && !expect_busy) begin
            if (!addr[1]) begin
                latched_cmd = data[15:8];
            end else begin
                case (latched_cmd)
                    CMD_READ_MODE: expect_read = 1'b1;
                    CMD_STATUS_MODE, CMD_READID_MODE, CMD_BUFFER_MODE,
                    CMD_ERASE_SECTOR, CMD_ERASE_CHIP: expect_read = 1'b0;
                    CMD_ERASE_START: begin
                        expect_read = 1'b0;
                        expect_busy = expect_armed;
                    end
                    CMD_WRITE_START: begin
                        expect_read = 1'b0;
                        expect_busy = 1'b1;
                    end
                    default: begin
                        // Unknown codes leave the mode alone
                    end
                endcase
                expect_armed = latched_cmd == CMD_ERASE_SECTOR ||
                               latched_cmd == CMD_ERASE_CHIP;
            end
        end
    endtask

    task automatic check_read_mode();
        if (!aborted && read_mode !== expect_read) begin
            $display("FAIL %0t: read_mode is %b, expected %b", $time, read_mode, expect_read);
            error_count++;
        end
    endtask

    // Word i gets upper_base + i in its upper half and lower_base + i in its lower half
    task automatic fill_buffer(input int count, input logic [15:0] upper_base,
                               input logic [15:0] lower_base);
        logic [15:0] unused;
        for (int i = 0; i < count; i++) begin
            bus_access(1'b1, ADDR_BITS'(i * 4), upper_base + 16'(i), unused);
            bus_access(1'b1, ADDR_BITS'(i * 4 + 2), lower_base + 16'(i), unused);
        end
    endtask

    task automatic close_test();
        if (test_open) begin
            if (error_count == 0) begin
                $display("test %s: PASS", test_name);
                pass_count++;
            end else begin
                $display("test %s: FAIL with %0d errors", test_name, error_count);
                fail_count++;
            end
        end else if (error_count != 0) begin
            // Errors ahead of the first test still count against the run
            fail_count++;
        end
        test_open = 1'b0;
        error_count = 0;
    endtask

    initial begin
        int               fd;
        int               code;
        int               bit_idx;
        int               expected_bit;
        logic             done;
        logic [7:0]       kind;
        logic [8*40-1:0]  name_raw;
        logic [8*120-1:0] comment_line;
        logic [31:0]      arg_a;
        logic [31:0]      arg_b;
        logic [31:0]      arg_c;
        logic [15:0]      got;

        sys = 1'b0;
        rst = 1'b1;
        request = 1'b0;
        write = 1'b0;
        address = '0;
        wdata = 16'h0000;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        test_open = 1'b0;
        aborted = 1'b0;
        test_name = "";
        done = 1'b0;
        expect_read = 1'b0;
        expect_busy = 1'b0;
        expect_armed = 1'b0;
        latched_cmd = 8'h00;

        repeat (2) @(posedge sys);
        @(negedge sys);
        rst = 1'b0;
        @(negedge sys);

        fd = $fopen("flashram_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file flashram_stim.txt");
            aborted = 1'b1;
        end else begin
            while (!done && !aborted) begin
                kind = 8'h00;
                if ($fscanf(fd, "%s", kind) != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    code = $fgets(comment_line, fd);
                end else if (kind == "T") begin
                    close_test();
                    name_raw = '0;
                    code = $fscanf(fd, "%s", name_raw);
                    test_name = to_text(name_raw);
                    test_open = 1'b1;
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    bus_access(1'b1, arg_a[ADDR_BITS-1:0], arg_b[15:0], got);
                    track_command(arg_a[ADDR_BITS-1:0], arg_b[15:0]);
                    check_read_mode();
                end else if (kind == "R") begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                    bus_access(1'b0, arg_a[ADDR_BITS-1:0], 16'h0000, got);
                    if (!aborted && got !== arg_b[15:0]) begin
                        $display("FAIL %0t: read at address %h expected %h got %h",
                                 $time, arg_a[ADDR_BITS-1:0], arg_b[15:0], got);
                        error_count++;
                    end
                    check_read_mode();
                end else if (kind == "P") begin
                    code = $fscanf(fd, "%d %d", bit_idx, expected_bit);
                    poll_status(bit_idx, expected_bit[0]);
                end else if (kind == "F") begin
                    code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                    fill_buffer(int'(arg_a), arg_b[15:0], arg_c[15:0]);
                end else begin
                    $display("The stimulus file has a line of unknown type %c", kind);
                    error_count++;
                end
            end
            $fclose(fd);
        end
        close_test();

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (aborted || fail_count != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

//--- flashram_stim.txt
# Columns: type letter, then fields in hex unless noted
# W addr data | R addr expected | P status_bit(dec) value(dec) | F words upper lower | T name
# ID words, then status mode right after reset
T id_read
W 10000 E100
W 10002 0000
R 00000 1111
R 00002 8001
R 00004 00C2
R 00006 001D
W 10000 D200
W 10002 0000
R 00000 0000
R 00002 0000
# Whole array erased, sampled in pages 0, 3 and 7
T chip_erase
W 10000 3C00
W 10002 0000
W 10000 7800
W 10002 0000
P 3 1
P 1 0
W 10000 F000
W 10002 0000
R 00000 FFFF
R 00002 FFFF
R 0019C FFFF
R 0019E FFFF
R 003FC FFFF
R 003FE FFFF
# Program page 5, then page 3 for the sector erase test
T page_program
W 10000 B400
W 10002 0000
F 20 A500 5A00
W 10000 A500
W 10002 0005
P 2 1
P 0 0
W 10000 B400
W 10002 0000
F 20 C300 3C00
W 10000 A500
W 10002 0003
P 2 1
W 10000 F000
W 10002 0000
R 00280 A500
R 00282 5A00
R 002FC A51F
R 002FE 5A1F
R 00200 FFFF
R 00202 FFFF
# Erase page 5 while page 3 keeps its data
T sector_erase
W 10000 4B00
W 10002 0005
W 10000 7800
W 10002 0000
P 3 1
P 1 0
W 10000 F000
W 10002 0000
R 00280 FFFF
R 002FE FFFF
R 00180 C300
R 00182 3C00
R 001FC C31F
R 001FE 3C1F
# Unarmed erase start, busy bit right after write start, command ignored while pending
T guard_rules
W 10000 D200
W 10002 0000
R 00002 000C
W 10000 7800
W 10002 0000
R 00002 000C
W 10000 B400
W 10002 0000
W 10000 A500
W 10002 0006
R 00002 0009
W 10000 E100
W 10002 0000
R 00002 0009
P 2 1
R 00002 000C

//--- sources.f
flashram_pkg.sv
flashram_page_buffer.sv
flashram_ctrl.sv
flashram_engine.sv
flashram_top.sv
tb_flashram.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_flashram
FILELIST = sources.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
